//--- sources.f
digit_pkg.sv
row_stream_if.sv
canvas_painter.sv
row_streamer.sv
template_scorer.sv
score_argmax.sv
recognizer_controller.sv
digit_recognizer_top.sv
digit_recognizer_checker.sv
digit_recognizer_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sources.f --top-module digit_recognizer_tb \
    -o digit_recognizer_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/digit_recognizer_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

//--- digit_recognizer_tb.sv
// Digit recognizer testbench
`timescale 1ns/10ps
`default_nettype none

module digit_recognizer_tb;

    localparam int clk_half_period = 20;
    localparam int reset_cycles    = 2;
    localparam int num_scenarios   = 11;
    // Worst case per entry: clear wait 8, paint 21, buttons 4, en low 30, latency 20, clear 8
    localparam int scenario_cycles = 120;
    localparam int max_cycles      = num_scenarios * scenario_cycles + 50;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;
    localparam logic [31:0] lfsr_seed = 32'd93680;
    localparam digit_pkg::digit_t blank_code = digit_pkg::digit_t'(digit_pkg::blank_digit);

    typedef enum logic [1:0] {src_empty, src_template, src_random} source_t;

    typedef struct packed {
        source_t    source;
        logic [3:0] tmpl;
        logic       end_button2;
        logic [5:0] en_low;
    } scenario_t;

    localparam scenario_t scenarios [num_scenarios] = '{
        '{source: src_template, tmpl: 4'd0, end_button2: 1'b0, en_low: 6'd0},
        '{source: src_template, tmpl: 4'd3, end_button2: 1'b0, en_low: 6'd0},
        '{source: src_template, tmpl: 4'd7, end_button2: 1'b0, en_low: 6'd0},
        '{source: src_template, tmpl: 4'd8, end_button2: 1'b1, en_low: 6'd0},
        '{source: src_empty,    tmpl: 4'd0, end_button2: 1'b0, en_low: 6'd0},
        '{source: src_random,   tmpl: 4'd0, end_button2: 1'b0, en_low: 6'd0},
        '{source: src_random,   tmpl: 4'd0, end_button2: 1'b1, en_low: 6'd0},
        '{source: src_random,   tmpl: 4'd0, end_button2: 1'b0, en_low: 6'd0},
        '{source: src_template, tmpl: 4'd5, end_button2: 1'b0, en_low: 6'd30},
        '{source: src_random,   tmpl: 4'd0, end_button2: 1'b1, en_low: 6'd12},
        '{source: src_template, tmpl: 4'd9, end_button2: 1'b0, en_low: 6'd0}
    };

    logic                  clk;
    logic                  reset;
    logic                  en;
    logic                  button1;
    logic                  button2;
    logic                  paint_valid;
    digit_pkg::row_index_t paint_row;
    digit_pkg::col_index_t paint_col;
    logic                  paint_ready;
    digit_pkg::digit_t     output_digit;

    logic [31:0]           lfsr_state;
    digit_pkg::canvas_t    canvas_model;
    int                    cycle_count = 0;
    int                    value_errors = 0;
    int                    other_errors = 0;

    digit_recognizer_top uut (
        .clk(clk), .reset(reset), .en(en), .button1(button1), .button2(button2),
        .paint_valid(paint_valid), .paint_row(paint_row), .paint_col(paint_col),
        .paint_ready(paint_ready), .output_digit(output_digit)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_half_period) clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            other_errors = other_errors + 1;
            $display("Timeout: the DUT did not respond within %0d cycles", max_cycles);
            $display("Checks done: %0d value errors, %0d other errors",
                     value_errors, other_errors);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ lfsr_taps;
        end
        return state >> 1;
    endfunction

    // Count of equal pixels per class, first maximum wins
    function automatic digit_pkg::digit_t reference_digit(input digit_pkg::canvas_t image);
        int best_class;
        int best_score;
        int score;
        best_class = 0;
        best_score = -1;
        for (int k = 0; k < digit_pkg::num_classes; k++) begin
            score = 0;
            for (int r = 0; r < digit_pkg::grid_rows; r++) begin
                for (int c = 0; c < digit_pkg::grid_cols; c++) begin
                    if (image[r][c] == digit_pkg::digit_templates[k][r][c]) begin
                        score = score + 1;
                    end
                end
            end
            if (score > best_score) begin
                best_score = score;
                best_class = k;
            end
        end
        return digit_pkg::digit_t'(best_class);
    endfunction

    task automatic compare_digit(input digit_pkg::digit_t actual,
                                 input digit_pkg::digit_t expected, input string name);
        if (actual !== expected) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic compare_ready(input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error: paint_ready = 0x%h, expected 0x%h at %0t",
                     actual, expected, $time);
            value_errors = value_errors + 1;
        end
    endtask

    task automatic build_canvas(input scenario_t sc);
        canvas_model = '0;
        case (sc.source)
            src_template: canvas_model = digit_pkg::digit_templates[sc.tmpl];
            src_random: begin
                // One LFSR step per pixel
                for (int r = 0; r < digit_pkg::grid_rows; r++) begin
                    for (int c = 0; c < digit_pkg::grid_cols; c++) begin
                        lfsr_state = lfsr_step(lfsr_state);
                        canvas_model[r][c] = lfsr_state[0];
                    end
                end
            end
            default: canvas_model = '0;
        endcase
    endtask

    task automatic wait_paint_ready();
        @(negedge clk);
        while (paint_ready !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_digit_shown();
        @(negedge clk);
        while (output_digit === blank_code) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_blank();
        @(negedge clk);
        while (output_digit !== blank_code) begin
            @(negedge clk);
        end
    endtask

    task automatic paint_canvas();
        for (int r = 0; r < digit_pkg::grid_rows; r++) begin
            for (int c = 0; c < digit_pkg::grid_cols; c++) begin
                if (canvas_model[r][c]) begin
                    @(posedge clk);
                    paint_valid <= 1'b1;
                    paint_row   <= digit_pkg::row_index_t'(r);
                    paint_col   <= digit_pkg::col_index_t'(c);
                    @(negedge clk);
                    compare_ready(paint_ready, 1'b1);
                end
            end
        end
        @(posedge clk);
        paint_valid <= 1'b0;
    endtask

    // One-cycle press, returns on the edge that samples it
    task automatic press_button(input logic second);
        @(posedge clk);
        if (second) begin
            button2 <= 1'b1;
        end else begin
            button1 <= 1'b1;
        end
        @(posedge clk);
        button1 <= 1'b0;
        button2 <= 1'b0;
    endtask

    task automatic run_scenario(input scenario_t sc);
        digit_pkg::digit_t expected;
        build_canvas(sc);
        expected = reference_digit(canvas_model);
        wait_paint_ready();
        paint_canvas();
        press_button(1'b0);
        if (sc.en_low != 6'd0) begin
            en <= 1'b0;
            // Controller frozen in the forward step
            repeat (sc.en_low) begin
                @(negedge clk);
                compare_digit(output_digit, blank_code, "output_digit");
            end
            @(posedge clk);
            en <= 1'b1;
        end
        wait_digit_shown();
        compare_digit(output_digit, expected, "output_digit");
        press_button(sc.end_button2);
        wait_blank();
        if (!sc.end_button2) begin
            wait_paint_ready();
        end
    endtask

    initial begin
        reset       = 1'b1;
        en          = 1'b1;
        button1     = 1'b0;
        button2     = 1'b0;
        paint_valid = 1'b0;
        paint_row   = '0;
        paint_col   = '0;
        lfsr_state  = lfsr_seed;

        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        // Initialization and the first clear take five cycles each
        repeat (2 * digit_pkg::grid_rows) begin
            @(negedge clk);
            compare_ready(paint_ready, 1'b0);
            compare_digit(output_digit, blank_code, "output_digit");
        end

        for (int i = 0; i < num_scenarios; i++) begin
            run_scenario(scenarios[i]);
        end

        $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- digit_recognizer_checker.sv
// Stream and controller assertions
`timescale 1ns/10ps
`default_nettype none

module digit_recognizer_checker #(
    parameter bit stream_side = 1'b0
) (
    input wire                         clk,
    input wire                         reset,
    input wire digit_pkg::credit_t     credits,
    input wire                         valid,
    input wire                         credit_return,
    input wire                         start,
    input wire digit_pkg::canvas_t     canvas,
    input wire digit_pkg::ctrl_state_t state,
    input wire digit_pkg::digit_t      output_digit
);

    generate
        if (stream_side) begin : g_stream
            // Rows sent and not yet freed in the scorer buffer
            digit_pkg::credit_t outstanding;

            always_ff @(posedge clk) begin
                if (reset) begin
                    outstanding <= '0;
                end else begin
                    outstanding <= outstanding + digit_pkg::credit_t'(valid)
                                   - digit_pkg::credit_t'(credit_return);
                end
            end

            credit_bound: assert property (@(posedge clk) disable iff (reset)
                credits <= digit_pkg::credit_t'(digit_pkg::row_credits))
                else $error("row credit count above the scorer buffer depth");

            valid_needs_credit: assert property (@(posedge clk) disable iff (reset)
                valid |-> outstanding < digit_pkg::credit_t'(digit_pkg::row_credits))
                else $error("row beat sent while the scorer buffer is full");

            canvas_frozen_in_step: assert property (@(posedge clk) disable iff (reset)
                start && $past(start) |-> $stable(canvas))
                else $error("canvas changed while the network runs");
        end else begin : g_controller
            digit_held_in_display: assert property (@(posedge clk) disable iff (reset)
                state == digit_pkg::state_display_digit
                && $past(state) == digit_pkg::state_display_digit
                |-> $stable(output_digit))
                else $error("shown digit changed during the display");
        end
    endgenerate

endmodule

// Fire is the streamer's valid beat
bind row_streamer digit_recognizer_checker #(.stream_side(1'b1)) stream_checks (
    .clk(clk), .reset(reset), .credits(credits), .valid(fire),
    .credit_return(rows.credit_return), .start(start), .canvas(canvas),
    .state(digit_pkg::state_reset),
    .output_digit(digit_pkg::digit_t'(digit_pkg::blank_digit))
);

bind recognizer_controller digit_recognizer_checker #(.stream_side(1'b0)) controller_checks (
    .clk(clk), .reset(reset), .credits('0), .valid(1'b0),
    .credit_return(1'b0), .start(1'b0), .canvas('0),
    .state(state), .output_digit(output_digit)
);

`default_nettype wire

//--- digit_recognizer_top.sv
// Digit recognizer top level
`timescale 1ns/10ps
`default_nettype none

module digit_recognizer_top (
    input  wire        clk,
    input  wire        reset,
    input  wire        en,
    input  wire        button1,
    input  wire        button2,
    input  wire        paint_valid,
    input  wire  [2:0] paint_row,
    input  wire  [1:0] paint_col,
    output logic       paint_ready,
    output logic [3:0] output_digit
);

    logic                     graphics_initialized;
    logic                     painter_ready;
    logic                     clear_canvas;
    logic                     enable_graphics;
    logic                     start_network;
    logic                     reset_network;
    logic                     network_reset;
    logic                     scores_valid;
    logic                     network_done;
    digit_pkg::digit_t        predicted_digit;
    digit_pkg::canvas_t       canvas;
    digit_pkg::score_vector_t scores;

    row_stream_if rows ();

    // Network side also held in reset by the controller
    assign network_reset = reset || reset_network;

    recognizer_controller u_controller (
        .clk(clk), .reset(reset), .en(en), .button1(button1), .button2(button2),
        .graphics_initialized(graphics_initialized), .painter_ready(painter_ready),
        .network_done(network_done), .predicted_digit(predicted_digit),
        .output_digit(output_digit), .clear_canvas(clear_canvas),
        .enable_graphics(enable_graphics), .start_network(start_network),
        .reset_network(reset_network)
    );

    canvas_painter u_painter (
        .clk(clk), .reset(reset), .clear_canvas(clear_canvas),
        .enable_graphics(enable_graphics), .paint_valid(paint_valid),
        .paint_row(paint_row), .paint_col(paint_col),
        .initialized(graphics_initialized), .ready(painter_ready),
        .paint_ready(paint_ready), .canvas(canvas)
    );

    row_streamer u_streamer (
        .clk(clk), .reset(network_reset), .start(start_network), .canvas(canvas),
        .rows(rows.sender)
    );

    template_scorer u_scorer (
        .clk(clk), .reset(network_reset), .rows(rows.receiver),
        .scores_valid(scores_valid), .scores(scores)
    );

    score_argmax u_argmax (
        .clk(clk), .reset(network_reset), .scores_valid(scores_valid), .scores(scores),
        .done(network_done), .digit(predicted_digit)
    );

endmodule

`default_nettype wire

//--- recognizer_controller.sv
// Recognizer master FSM
`timescale 1ns/10ps
`default_nettype none

module recognizer_controller (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    en,
    input  wire                    button1,
    input  wire                    button2,
    input  wire                    graphics_initialized,
    input  wire                    painter_ready,
    input  wire                    network_done,
    input  wire digit_pkg::digit_t predicted_digit,
    output digit_pkg::digit_t      output_digit,
    output logic                   clear_canvas,
    output logic                   enable_graphics,
    output logic                   start_network,
    output logic                   reset_network
);

    digit_pkg::ctrl_state_t state;
    digit_pkg::ctrl_state_t state_next;
    digit_pkg::digit_t      digit_latched;
    logic                   done_pending;
    logic                   done_seen;

    assign done_seen = network_done || done_pending;

    assign output_digit = (state == digit_pkg::state_display_digit) ? digit_latched
                          : digit_pkg::digit_t'(digit_pkg::blank_digit);

    // The network keeps running with en low, so its done is held here
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= digit_pkg::state_reset;
            done_pending <= 1'b0;
        end else if (en) begin
            state        <= state_next;
            done_pending <= 1'b0;
        end else if (network_done) begin
            done_pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (network_done) begin
            digit_latched <= predicted_digit;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            digit_pkg::state_reset:
                if (graphics_initialized) state_next = digit_pkg::state_clear_start;
            digit_pkg::state_clear_start:
                state_next = button2 ? digit_pkg::state_reset : digit_pkg::state_clear_wait;
            digit_pkg::state_clear_wait:
                if (button2) state_next = digit_pkg::state_reset;
                else if (painter_ready) state_next = digit_pkg::state_idle;
            digit_pkg::state_idle:
                if (button2) state_next = digit_pkg::state_reset;
                else if (button1) state_next = digit_pkg::state_forward_step;
            // Done wins over button2 here
            digit_pkg::state_forward_step:
                if (done_seen) state_next = digit_pkg::state_display_digit;
                else if (button2) state_next = digit_pkg::state_reset;
            digit_pkg::state_display_digit:
                if (button2) state_next = digit_pkg::state_reset;
                else if (button1) state_next = digit_pkg::state_clear_start;
            default:
                state_next = digit_pkg::state_reset;
        endcase
    end

    // Outputs decoded from the state alone
    always_comb begin
        clear_canvas    = 1'b0;
        enable_graphics = 1'b0;
        start_network   = 1'b0;
        reset_network   = 1'b1;
        case (state)
            digit_pkg::state_clear_start: begin
                clear_canvas    = 1'b1;
                enable_graphics = 1'b1;
            end
            digit_pkg::state_clear_wait,
            digit_pkg::state_idle: begin
                enable_graphics = 1'b1;
            end
            digit_pkg::state_forward_step: begin
                start_network = 1'b1;
                reset_network = 1'b0;
            end
            digit_pkg::state_display_digit: begin
                reset_network = 1'b0;
            end
            default: begin
                clear_canvas = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- score_argmax.sv
// Winning class selector
`timescale 1ns/10ps
`default_nettype none

module score_argmax (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           scores_valid,
    input  wire digit_pkg::score_vector_t scores,
    output logic                          done,
    output digit_pkg::digit_t             digit
);

    digit_pkg::digit_t best_idx;
    digit_pkg::score_t best_score;

    // Strict compare keeps the lowest index on a tie
    always_comb begin
        best_idx   = '0;
        best_score = scores[0];
        for (int k = 1; k < digit_pkg::num_classes; k++) begin
            if (scores[k] > best_score) begin
                best_score = scores[k];
                best_idx   = digit_pkg::digit_t'(k);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= scores_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (scores_valid) begin
            digit <= best_idx;
        end
    end

endmodule

`default_nettype wire

//--- template_scorer.sv
// Template match scorer
`timescale 1ns/10ps
`default_nettype none

module template_scorer (
    input  wire                      clk,
    input  wire                      reset,
    row_stream_if.receiver           rows,
    output logic                     scores_valid,
    output digit_pkg::score_vector_t scores
);

    typedef struct packed {
        logic                   last;
        digit_pkg::row_index_t  index;
        digit_pkg::canvas_row_t data;
    } beat_t;

    beat_t                    buffer [digit_pkg::row_credits];
    beat_t                    stage;
    logic                     wr_ptr;
    logic                     rd_ptr;
    digit_pkg::credit_t       count;
    logic                     pop;
    logic                     stage_valid;
    digit_pkg::score_vector_t acc;
    digit_pkg::score_vector_t sum;

    function automatic digit_pkg::score_t match_count(
        input digit_pkg::canvas_row_t row,
        input digit_pkg::canvas_row_t tmpl
    );
        digit_pkg::score_t n;
        n = '0;
        for (int c = 0; c < digit_pkg::grid_cols; c++) begin
            n = n + digit_pkg::score_t'(row[c] == tmpl[c]);
        end
        return n;
    endfunction

    assign pop = (count != '0);

    always_comb begin
        for (int k = 0; k < digit_pkg::num_classes; k++) begin
            sum[k] = acc[k] + match_count(stage.data, digit_pkg::digit_templates[k][stage.index]);
        end
    end

    // Buffer control, one pop per cycle, credit follows the pop
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr        <= 1'b0;
            rd_ptr        <= 1'b0;
            count         <= '0;
            stage_valid   <= 1'b0;
            rows.credit_return <= 1'b0;
            scores_valid  <= 1'b0;
            acc           <= '0;
        end else begin
            if (rows.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + digit_pkg::credit_t'(rows.valid) - digit_pkg::credit_t'(pop);
            stage_valid        <= pop;
            rows.credit_return <= pop;
            scores_valid       <= stage_valid && stage.last;
            if (stage_valid) begin
                acc <= stage.last ? '0 : sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rows.valid) begin
            buffer[wr_ptr] <= '{last: rows.last, index: rows.row_index, data: rows.row_data};
        end
        if (pop) begin
            stage <= buffer[rd_ptr];
        end
        if (stage_valid && stage.last) begin
            scores <= sum;
        end
    end

endmodule

`default_nettype wire

//--- row_streamer.sv
// Canvas row streamer
`timescale 1ns/10ps
`default_nettype none

module row_streamer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     start,
    input  wire digit_pkg::canvas_t canvas,
    row_stream_if.sender            rows
);

    digit_pkg::canvas_t    snapshot;
    digit_pkg::row_index_t row_ptr;
    digit_pkg::credit_t    credits;
    logic                  sending;
    logic                  launched;
    logic                  fire;

    // Start is a level during the forward step, so only the first cycle launches
    assign fire           = sending && (credits != '0);
    assign rows.valid     = fire;
    assign rows.row_data  = snapshot[row_ptr];
    assign rows.row_index = row_ptr;
    assign rows.last      = (row_ptr == digit_pkg::row_index_t'(digit_pkg::grid_rows - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            sending  <= 1'b0;
            launched <= 1'b0;
            row_ptr  <= '0;
            credits  <= digit_pkg::credit_t'(digit_pkg::row_credits);
        end else begin
            if (start && !launched) begin
                sending  <= 1'b1;
                launched <= 1'b1;
                row_ptr  <= '0;
            end else if (fire) begin
                row_ptr <= row_ptr + 1'b1;
                if (rows.last) begin
                    sending <= 1'b0;
                end
            end
            credits <= credits + digit_pkg::credit_t'(rows.credit_return)
                       - digit_pkg::credit_t'(fire);
        end
    end

    always_ff @(posedge clk) begin
        if (start && !launched) begin
            snapshot <= canvas;
        end
    end

endmodule

`default_nettype wire

//--- canvas_painter.sv
// Bitmap canvas painter
`timescale 1ns/10ps
`default_nettype none

module canvas_painter (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        clear_canvas,
    input  wire                        enable_graphics,
    input  wire                        paint_valid,
    input  wire digit_pkg::row_index_t paint_row,
    input  wire digit_pkg::col_index_t paint_col,
    output logic                       initialized,
    output logic                       ready,
    output logic                       paint_ready,
    output digit_pkg::canvas_t         canvas
);

    logic                  clearing;
    digit_pkg::row_index_t clear_row;
    logic                  last_clear_row;

    assign last_clear_row = (clear_row == digit_pkg::row_index_t'(digit_pkg::grid_rows - 1));

    // Ready already on the last clear row, so the controller reaches idle as the clear ends
    assign ready       = !clearing || last_clear_row;
    assign paint_ready = enable_graphics && !clearing && !clear_canvas;

    // Row-wise clear sequencer, also run once after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing    <= 1'b1;
            clear_row   <= '0;
            initialized <= 1'b0;
        end else if (clear_canvas && enable_graphics) begin
            clearing  <= 1'b1;
            clear_row <= '0;
        end else if (clearing) begin
            clear_row <= clear_row + 1'b1;
            if (last_clear_row) begin
                clearing    <= 1'b0;
                initialized <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clearing) begin
            canvas[clear_row] <= '0;
        end else if (paint_valid && paint_ready
                     && paint_row < digit_pkg::row_index_t'(digit_pkg::grid_rows)) begin
            canvas[paint_row][paint_col] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- row_stream_if.sv
// Credit-based row stream
`timescale 1ns/10ps
`default_nettype none

interface row_stream_if;

    logic                   valid;
    digit_pkg::canvas_row_t row_data;
    digit_pkg::row_index_t  row_index;
    logic                   last;
    // One pulse for each row freed in the receiver buffer
    logic                   credit_return;

    modport sender (output valid, row_data, row_index, last, input credit_return);

    modport receiver (input valid, row_data, row_index, last, output credit_return);

endinterface

`default_nettype wire

//--- digit_pkg.sv
// Digit recognizer shared definitions
`default_nettype none

package digit_pkg;

    localparam int grid_rows    = 5;
    localparam int grid_cols    = 4;
    localparam int num_classes  = 10;
    localparam int row_credits  = 2;
    localparam int blank_digit  = 10;
    localparam int credit_width = $clog2(row_credits + 1);

    // Bit c of a row is column c
    typedef logic [grid_cols-1:0]            canvas_row_t;
    typedef canvas_row_t [0:grid_rows-1]     canvas_t;
    typedef logic [2:0]                      row_index_t;
    typedef logic [1:0]                      col_index_t;
    typedef logic [4:0]                      score_t;
    typedef score_t [num_classes-1:0]        score_vector_t;
    typedef logic [3:0]                      digit_t;
    typedef logic [credit_width-1:0]         credit_t;

    // Reference bitmaps, row 0 at the top
    localparam canvas_t digit_templates [num_classes] = '{
        '{4'b0110, 4'b1001, 4'b1001, 4'b1001, 4'b0110},
        '{4'b0010, 4'b0110, 4'b0010, 4'b0010, 4'b0111},
        '{4'b1110, 4'b0001, 4'b0110, 4'b1000, 4'b1111},
        '{4'b1110, 4'b0001, 4'b0110, 4'b0001, 4'b1110},
        '{4'b1001, 4'b1001, 4'b1111, 4'b0001, 4'b0001},
        '{4'b1111, 4'b1000, 4'b1110, 4'b0001, 4'b1110},
        '{4'b0110, 4'b1000, 4'b1110, 4'b1001, 4'b0110},
        '{4'b1111, 4'b0001, 4'b0010, 4'b0100, 4'b0100},
        '{4'b0110, 4'b1001, 4'b0110, 4'b1001, 4'b0110},
        '{4'b0110, 4'b1001, 4'b0111, 4'b0001, 4'b0110}
    };

    // Master FSM states
    typedef enum logic [2:0] {
        state_reset,
        state_clear_start,
        state_clear_wait,
        state_idle,
        state_forward_step,
        state_display_digit
    } ctrl_state_t;

endpackage

`default_nettype wire
